/* verification/dsp_stim.txt */
# w <sel> <word addr> <data> : host write, sel 0 commands, 1 envelope, others write nothing
# d <sample> : expected dac sample of one shot, in order
# r <nshot> <window length> : start a run and check it; every field is hex
w 1 0000 20001000
w 1 0001 e0004000
w 1 0002 0800f000
w 0 0000 40006400
w 0 0001 40202c00
w 0 0002 8000a000
w 0 0003 00000000
w 2 0000 ffffffff
d 0080
d 0100
d 0200
d ff00
d ff80
d 0040
d fe00
d 0100
r 3 a
r 0 a
r 5 a

/* verilog.f */
verilog/dsp_cfg_pkg.sv
verilog/dsp_cmd_pkg.sv
verilog/aligned_ram.sv
verilog/param_mem_bank.sv
verilog/seq_ctrl.sv
verilog/pulse_gen.sv
verilog/acq_accum.sv
verilog/dsp_sim_top.sv
verification/dsp_sim_tb.sv

/* verification/dsp_sim_tb.sv */
module dsp_sim_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] SEED = 32'he615_29ca;
    localparam int RISE_TIMEOUT = 20;     // cycles.
    localparam int RUN_TIMEOUT  = 20000;  // cycles.
    localparam string STIM_FILE = "verification/dsp_stim.txt";

    logic        clk;
    logic        rst_n;
    logic        stb_start;
    logic [31:0] nshot;
    logic [31:0] mem_write_data;
    logic [15:0] mem_write_addr;
    logic [2:0]  mem_write_sel;
    logic        mem_write_en;
    logic [7:0]  buf_read_addr;
    logic [15:0] adc;
    logic [15:0] dac;
    logic        busy;
    logic        acq_gate;
    logic [31:0] acc_read_data;
    logic [15:0] acq_read_data;

    int          mismatches;
    int          failures;
    logic [31:0] rng;
    logic [15:0] exp_dac [$];
    logic [15:0] cur_samples [$];
    logic [15:0] last_samples [$];
    logic [31:0] shot_sums [$];
    logic [31:0] cur_sum;
    int          dac_idx;
    int          gate_len;
    int          windows;
    int          exp_window;
    logic        monitor_on;
    logic        prev_gate;

    dsp_sim_top #(.SHIFT(15)) dut_i (
        .clk(clk), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
        .mem_write_data(mem_write_data), .mem_write_addr(mem_write_addr),
        .mem_write_sel(mem_write_sel), .mem_write_en(mem_write_en),
        .buf_read_addr(buf_read_addr), .adc(adc), .dac(dac), .busy(busy),
        .acq_gate(acq_gate), .acc_read_data(acc_read_data), .acq_read_data(acq_read_data));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual) begin
            mismatches++;
            $display("Mismatch at %0t: %s expected 0x%0h, actual 0x%0h",
                     $time, name, expected, actual);
        end
    endtask

    // ----------------------------------------
    // adc source and output monitor
    // ----------------------------------------
    initial begin
        adc = '0;
        rng = SEED;
        forever begin
            @(posedge clk);
            #2;
            rng = xorshift(rng);
            adc = rng[15:0];
        end
    end

    task automatic close_window();
        compare_value("acq_gate window length", exp_window, gate_len);
        compare_value("dac sample count", exp_dac.size(), dac_idx);
        shot_sums.push_back(cur_sum);
        last_samples = cur_samples;
        windows++;
        gate_len = 0;
        dac_idx  = 0;
    endtask

    // mid-cycle values match what the DUT takes at the next edge.
    always @(negedge clk) begin
        if (monitor_on) begin
            if (acq_gate === 1'b1) begin
                if (prev_gate !== 1'b1) begin
                    cur_samples.delete();
                    cur_sum = '0;
                end
                cur_samples.push_back(adc);
                cur_sum = cur_sum + {{16{adc[15]}}, adc};
                gate_len++;
            end else if (prev_gate === 1'b1) begin
                close_window();
            end
            if (dac !== '0) begin
                compare_value("dac", exp_dac[dac_idx], dac);
                dac_idx++;
            end
        end
        prev_gate = acq_gate;
    end

    // ----------------------------------------
    // stimulus tasks
    // ----------------------------------------
    task automatic host_write(input logic [2:0] sel, input logic [15:0] addr,
                              input logic [31:0] data);
        @(posedge clk);
        #2;
        mem_write_sel  = sel;
        mem_write_addr = addr;
        mem_write_data = data;
        mem_write_en   = 1'b1;
        @(posedge clk);
        #2;
        mem_write_en   = 1'b0;
    endtask

    task automatic wait_for_busy(input logic level, input int limit, output bit ok);
        int n;
        n  = 0;
        ok = 1'b0;
        while (n < limit && !ok) begin
            @(negedge clk);
            if (busy === level) ok = 1'b1;
            n++;
        end
    endtask

    task automatic start_strobe();
        @(posedge clk);
        #2;
        stb_start = 1'b1;
        @(posedge clk);
        #2;
        stb_start = 1'b0;
    endtask

    task automatic run_shots(input logic [31:0] shots, input int wlen, output bit ok);
        int expected_shots;
        int j;
        expected_shots = (shots == 0) ? 1 : shots;  // zero still runs one shot.
        exp_window = wlen;
        windows    = 0;
        gate_len   = 0;
        dac_idx    = 0;
        shot_sums.delete();
        @(posedge clk);
        #2;
        nshot = shots;
        start_strobe();
        wait_for_busy(1'b1, RISE_TIMEOUT, ok);
        if (!ok) begin
            $display("busy did not rise after stb_start");
            failures++;
            return;
        end
        repeat (3) @(posedge clk);
        start_strobe();  // lands mid-run.
        wait_for_busy(1'b0, RUN_TIMEOUT, ok);
        if (!ok) begin
            $display("busy did not fall");
            failures++;
            return;
        end
        repeat (4) @(negedge clk);
        compare_value("busy after run", 0, busy);
        compare_value("acq_gate window count", expected_shots, windows);
        for (j = 0; j < wlen; j++) begin
            @(posedge clk);
            #2;
            buf_read_addr = j[7:0];
            @(posedge clk);
            @(negedge clk);
            compare_value("acq_read_data", last_samples[j], acq_read_data);
        end
        for (j = 0; j < expected_shots; j++) begin
            @(posedge clk);
            #2;
            buf_read_addr = j[7:0];
            @(posedge clk);
            @(negedge clk);
            compare_value("acc_read_data", shot_sums[j], acc_read_data);
        end
    endtask

    task automatic report_result();
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        int          fd;
        int          cnt;
        string       line;
        string       tag;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        bit          ok;
        rst_n          = 1'b0;
        stb_start      = 1'b0;
        nshot          = '0;
        mem_write_data = '0;
        mem_write_addr = '0;
        mem_write_sel  = '0;
        mem_write_en   = 1'b0;
        buf_read_addr  = '0;
        mismatches     = 0;
        failures       = 0;
        monitor_on     = 1'b0;
        cur_sum        = '0;
        begin : test_body
            repeat (16) @(posedge clk);
            #2;
            rst_n = 1'b1;
            @(negedge clk);
            compare_value("busy after reset", 0, busy);
            compare_value("acq_gate after reset", 0, acq_gate);
            compare_value("dac after reset", 0, dac);
            monitor_on = 1'b1;
            fd = $fopen(STIM_FILE, "r");
            if (fd == 0) begin
                $display("could not open the stim file %s", STIM_FILE);
                failures++;
                disable test_body;
            end
            while (!$feof(fd)) begin
                cnt = $fgets(line, fd);
                if (cnt > 0) begin
                    cnt = $sscanf(line, "%s %h %h %h", tag, a, b, c);
                    case (tag)
                        "w": host_write(a[2:0], b[15:0], c);
                        "d": exp_dac.push_back(a[15:0]);
                        "r": begin
                            run_shots(a, b, ok);
                            if (!ok) disable test_body;
                        end
                        default: ;  // comment line.
                    endcase
                end
            end
            $fclose(fd);
        end
        report_result();
    end

endmodule

/* verilog/dsp_sim_top.sv */
module dsp_sim_top #(
    parameter int SHIFT = 15
) (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic                                     stb_start,
    input  logic [31:0]                              nshot,
    input  logic [dsp_cfg_pkg::HOST_DATA_WIDTH-1:0] mem_write_data,
    input  logic [dsp_cfg_pkg::HOST_ADDR_WIDTH-1:0] mem_write_addr,
    input  logic [dsp_cmd_pkg::SEL_WIDTH-1:0]       mem_write_sel,
    input  logic                                     mem_write_en,
    input  logic [dsp_cfg_pkg::ACQ_ADDR_WIDTH-1:0]  buf_read_addr,
    input  logic [dsp_cfg_pkg::ADC_WIDTH-1:0]       adc,
    output logic [dsp_cfg_pkg::DAC_WIDTH-1:0]       dac,
    output logic                                     busy,
    output logic                                     acq_gate,
    output logic [dsp_cfg_pkg::ACC_WIDTH-1:0]       acc_read_data,
    output logic [dsp_cfg_pkg::ADC_WIDTH-1:0]       acq_read_data
);

    logic [dsp_cfg_pkg::CMD_ADDR_WIDTH-1:0] cmd_read_addr;
    logic [dsp_cmd_pkg::CMD_WORD_WIDTH-1:0] cmd_data;
    logic [dsp_cfg_pkg::ENV_ADDR_WIDTH-1:0] env_read_addr;
    logic [dsp_cfg_pkg::ENV_WIDTH-1:0]      env_data;
    logic                                    pulse_start;
    logic                                    pulse_done;
    logic [dsp_cfg_pkg::ENV_ADDR_WIDTH-1:0] env_start;
    logic [dsp_cmd_pkg::LEN_WIDTH-1:0]      pulse_len;
    logic [dsp_cmd_pkg::AMP_WIDTH-1:0]      amplitude;
    logic [dsp_cfg_pkg::ACC_ADDR_WIDTH-1:0] shot_idx;
    logic                                    shot_end;

    param_mem_bank mem_bank_i (
        .clk(clk), .mem_write_data(mem_write_data), .mem_write_addr(mem_write_addr),
        .mem_write_sel(mem_write_sel), .mem_write_en(mem_write_en),
        .cmd_read_addr(cmd_read_addr), .env_read_addr(env_read_addr),
        .cmd_data(cmd_data), .env_data(env_data));

    seq_ctrl seq_ctrl_i (
        .clk(clk), .rst_n(rst_n), .stb_start(stb_start), .nshot(nshot),
        .cmd_data(cmd_data), .pulse_done(pulse_done), .busy(busy),
        .cmd_read_addr(cmd_read_addr), .pulse_start(pulse_start), .env_start(env_start),
        .pulse_len(pulse_len), .amplitude(amplitude), .acq_gate(acq_gate),
        .shot_idx(shot_idx), .shot_end(shot_end));

    pulse_gen #(.SHIFT(SHIFT)) pulse_gen_i (
        .clk(clk), .rst_n(rst_n), .pulse_start(pulse_start), .env_start(env_start),
        .pulse_len(pulse_len), .amplitude(amplitude), .env_data(env_data),
        .env_read_addr(env_read_addr), .dac(dac), .pulse_done(pulse_done));

    acq_accum acq_accum_i (
        .clk(clk), .rst_n(rst_n), .adc(adc), .acq_gate(acq_gate), .shot_idx(shot_idx),
        .shot_end(shot_end), .buf_read_addr(buf_read_addr),
        .acq_read_data(acq_read_data), .acc_read_data(acc_read_data));

endmodule

/* verilog/acq_accum.sv */
module acq_accum (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic [dsp_cfg_pkg::ADC_WIDTH-1:0]      adc,
    input  logic                                    acq_gate,
    input  logic [dsp_cfg_pkg::ACC_ADDR_WIDTH-1:0] shot_idx,
    input  logic                                    shot_end,
    input  logic [dsp_cfg_pkg::ACQ_ADDR_WIDTH-1:0] buf_read_addr,
    output logic [dsp_cfg_pkg::ADC_WIDTH-1:0]      acq_read_data,
    output logic [dsp_cfg_pkg::ACC_WIDTH-1:0]      acc_read_data
);

    localparam int PAD_WIDTH = dsp_cfg_pkg::ACC_WIDTH - dsp_cfg_pkg::ADC_WIDTH;

    logic [dsp_cfg_pkg::ACQ_ADDR_WIDTH-1:0] sample_idx;
    logic signed [dsp_cfg_pkg::ACC_WIDTH-1:0] sample_ext;
    logic signed [dsp_cfg_pkg::ACC_WIDTH-1:0] run_sum;

    assign sample_ext = {{PAD_WIDTH{adc[dsp_cfg_pkg::ADC_WIDTH-1]}}, adc};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample_idx <= '0;
        end else if (acq_gate) begin
            sample_idx <= sample_idx + 1'b1;
        end else begin
            sample_idx <= '0;
        end
    end

    // first sample of a window restarts the sum.
    always_ff @(posedge clk) begin
        if (acq_gate) begin
            run_sum <= ((sample_idx == '0) ? '0 : run_sum) + sample_ext;
        end
    end

    // ----------------------------------------
    // readback buffers
    // ----------------------------------------
    aligned_ram #(.DIN_WIDTH(dsp_cfg_pkg::ADC_WIDTH), .N_DIN_TO_DOUT(1),
                  .DOUT_ADDR_WIDTH(dsp_cfg_pkg::ACQ_ADDR_WIDTH),
                  .READ_LATENCY(dsp_cfg_pkg::BUF_READ_LATENCY))
        acq_buf (.clk(clk), .write_data(adc), .write_addr(sample_idx),
                 .write_enable(acq_gate), .read_addr(buf_read_addr),
                 .read_data(acq_read_data));

    aligned_ram #(.DIN_WIDTH(dsp_cfg_pkg::ACC_WIDTH), .N_DIN_TO_DOUT(1),
                  .DOUT_ADDR_WIDTH(dsp_cfg_pkg::ACC_ADDR_WIDTH),
                  .READ_LATENCY(dsp_cfg_pkg::BUF_READ_LATENCY))
        acc_buf (.clk(clk), .write_data(run_sum), .write_addr(shot_idx),
                 .write_enable(shot_end),
                 .read_addr(buf_read_addr[dsp_cfg_pkg::ACC_ADDR_WIDTH-1:0]),
                 .read_data(acc_read_data));

    // shot_end marks the cycle right after a window closes.
    assert property (@(posedge clk) disable iff (!rst_n)
        shot_end |-> !acq_gate && $past(acq_gate));

endmodule

/* verilog/pulse_gen.sv */
module pulse_gen #(
    parameter int SHIFT = 15
) (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    pulse_start,
    input  logic [dsp_cfg_pkg::ENV_ADDR_WIDTH-1:0] env_start,
    input  logic [dsp_cmd_pkg::LEN_WIDTH-1:0]      pulse_len,
    input  logic [dsp_cmd_pkg::AMP_WIDTH-1:0]      amplitude,
    input  logic [dsp_cfg_pkg::ENV_WIDTH-1:0]      env_data,
    output logic [dsp_cfg_pkg::ENV_ADDR_WIDTH-1:0] env_read_addr,
    output logic [dsp_cfg_pkg::DAC_WIDTH-1:0]      dac,
    output logic                                    pulse_done
);

    localparam int LAT        = dsp_cfg_pkg::PARAM_READ_LATENCY;
    localparam int PROD_WIDTH = dsp_cfg_pkg::ENV_WIDTH + dsp_cmd_pkg::AMP_WIDTH;

    logic                              issue;
    logic [dsp_cmd_pkg::LEN_WIDTH-1:0] remain;
    logic [LAT-1:0]                    valid_pipe;
    logic [LAT-1:0]                    last_pipe;
    logic signed [PROD_WIDTH-1:0]      product;
    logic signed [PROD_WIDTH-1:0]      scaled;

    assign product = $signed(env_data) * $signed(amplitude);
    assign scaled  = product >>> SHIFT;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            issue         <= 1'b0;
            remain        <= '0;
            env_read_addr <= '0;
            valid_pipe    <= '0;
            last_pipe     <= '0;
            dac           <= '0;
            pulse_done    <= 1'b0;
        end else begin
            if (pulse_start) begin
                issue         <= 1'b1;
                remain        <= pulse_len;
                env_read_addr <= env_start;
            end else if (issue) begin
                remain        <= remain - 1'b1;
                env_read_addr <= env_read_addr + 1'b1;
                if (remain == 1) begin
                    issue <= 1'b0;  // last address out.
                end
            end
            // markers follow the memory read latency.
            valid_pipe <= {valid_pipe[LAT-2:0], issue};
            last_pipe  <= {last_pipe[LAT-2:0], issue && (remain == 1)};
            dac        <= valid_pipe[LAT-1] ? scaled[dsp_cfg_pkg::DAC_WIDTH-1:0] : '0;
            pulse_done <= last_pipe[LAT-1];
        end
    end

endmodule

/* verilog/seq_ctrl.sv */
module seq_ctrl (
    input  logic                                    clk,
    input  logic                                    rst_n,
    input  logic                                    stb_start,
    input  logic [31:0]                             nshot,
    input  logic [dsp_cmd_pkg::CMD_WORD_WIDTH-1:0] cmd_data,
    input  logic                                    pulse_done,
    output logic                                    busy,
    output logic [dsp_cfg_pkg::CMD_ADDR_WIDTH-1:0] cmd_read_addr,
    output logic                                    pulse_start,
    output logic [dsp_cfg_pkg::ENV_ADDR_WIDTH-1:0] env_start,
    output logic [dsp_cmd_pkg::LEN_WIDTH-1:0]      pulse_len,
    output logic [dsp_cmd_pkg::AMP_WIDTH-1:0]      amplitude,
    output logic                                    acq_gate,
    output logic [dsp_cfg_pkg::ACC_ADDR_WIDTH-1:0] shot_idx,
    output logic                                    shot_end
);

    localparam int WAIT_WIDTH = $clog2(dsp_cfg_pkg::PARAM_READ_LATENCY) + 1;

    typedef enum logic [2:0] {
        S_IDLE,
        S_FETCH,
        S_WAIT,
        S_DECODE,
        S_PULSE,
        S_ACQ,
        S_NEXT
    } state_t;

    state_t                              state;
    logic [WAIT_WIDTH-1:0]               wait_cnt;
    logic [dsp_cmd_pkg::LEN_WIDTH-1:0]   acq_cnt;
    logic [31:0]                         shot_cnt;
    logic [31:0]                         shot_last;
    logic [dsp_cmd_pkg::OP_WIDTH-1:0]    opcode;

    assign opcode   = cmd_data[dsp_cmd_pkg::OP_LSB +: dsp_cmd_pkg::OP_WIDTH];
    assign shot_idx = shot_cnt[dsp_cfg_pkg::ACC_ADDR_WIDTH-1:0];

    // ----------------------------------------
    // command FSM
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= S_IDLE;
            busy          <= 1'b0;
            cmd_read_addr <= '0;
            pulse_start   <= 1'b0;
            acq_gate      <= 1'b0;
            shot_end      <= 1'b0;
            shot_cnt      <= '0;
            acq_cnt       <= '0;
            wait_cnt      <= '0;
        end else begin
            pulse_start <= 1'b0;
            shot_end    <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (stb_start) begin
                        busy          <= 1'b1;
                        cmd_read_addr <= '0;
                        shot_cnt      <= '0;
                        state         <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    wait_cnt <= WAIT_WIDTH'(dsp_cfg_pkg::PARAM_READ_LATENCY - 1);
                    state    <= S_WAIT;
                end
                S_WAIT: begin
                    if (wait_cnt <= 1) begin
                        state <= S_DECODE;  // cmd_data valid next cycle.
                    end else begin
                        wait_cnt <= wait_cnt - 1'b1;
                    end
                end
                S_DECODE: begin
                    cmd_read_addr <= cmd_read_addr + 1'b1;
                    case (opcode)
                        dsp_cmd_pkg::OP_PULSE: begin
                            pulse_start <= 1'b1;
                            state       <= S_PULSE;
                        end
                        dsp_cmd_pkg::OP_ACQ: begin
                            acq_gate <= 1'b1;
                            acq_cnt  <= cmd_data[dsp_cmd_pkg::LEN_LSB +: dsp_cmd_pkg::LEN_WIDTH];
                            state    <= S_ACQ;
                        end
                        dsp_cmd_pkg::OP_END: begin
                            if (shot_cnt == shot_last) begin
                                busy  <= 1'b0;
                                state <= S_IDLE;
                            end else begin
                                state <= S_NEXT;
                            end
                        end
                        default: state <= S_FETCH;  // unknown opcode skipped.
                    endcase
                end
                S_PULSE: begin
                    if (pulse_done) begin
                        state <= S_FETCH;
                    end
                end
                S_ACQ: begin
                    if (acq_cnt == 1) begin
                        acq_gate <= 1'b0;
                        shot_end <= 1'b1;
                        state    <= S_FETCH;
                    end else begin
                        acq_cnt <= acq_cnt - 1'b1;
                    end
                end
                S_NEXT: begin
                    cmd_read_addr <= '0;
                    shot_cnt      <= shot_cnt + 1'b1;
                    state         <= S_FETCH;
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == S_IDLE && stb_start) begin
            shot_last <= (nshot == '0) ? '0 : nshot - 32'd1;  // nshot of 0 runs once.
        end
        if (state == S_DECODE && opcode == dsp_cmd_pkg::OP_PULSE) begin
            env_start <= cmd_data[dsp_cmd_pkg::ENV_LSB +: dsp_cfg_pkg::ENV_ADDR_WIDTH];
            pulse_len <= cmd_data[dsp_cmd_pkg::LEN_LSB +: dsp_cmd_pkg::LEN_WIDTH];
            amplitude <= cmd_data[dsp_cmd_pkg::AMP_LSB +: dsp_cmd_pkg::AMP_WIDTH];
        end
    end

    // no acquisition window until the pulse generator reports done.
    assert property (@(posedge clk) disable iff (!rst_n)
        pulse_start |-> (!acq_gate until_with pulse_done));

endmodule

/* verilog/param_mem_bank.sv */
module param_mem_bank (
    input  logic                                     clk,
    input  logic [dsp_cfg_pkg::HOST_DATA_WIDTH-1:0] mem_write_data,
    input  logic [dsp_cfg_pkg::HOST_ADDR_WIDTH-1:0] mem_write_addr,
    input  logic [dsp_cmd_pkg::SEL_WIDTH-1:0]       mem_write_sel,
    input  logic                                     mem_write_en,
    input  logic [dsp_cfg_pkg::CMD_ADDR_WIDTH-1:0]  cmd_read_addr,
    input  logic [dsp_cfg_pkg::ENV_ADDR_WIDTH-1:0]  env_read_addr,
    output logic [dsp_cmd_pkg::CMD_WORD_WIDTH-1:0]  cmd_data,
    output logic [dsp_cfg_pkg::ENV_WIDTH-1:0]       env_data
);

    localparam int LAT          = dsp_cfg_pkg::PARAM_READ_LATENCY;
    localparam int ENV_PER_WORD = dsp_cfg_pkg::HOST_DATA_WIDTH / dsp_cfg_pkg::ENV_WIDTH;
    localparam int SUB_WIDTH    = $clog2(ENV_PER_WORD);
    localparam int ENV_WA_WIDTH = dsp_cfg_pkg::ENV_ADDR_WIDTH - SUB_WIDTH;

    logic                                    cmd_we;
    logic                                    env_we;
    logic [dsp_cfg_pkg::HOST_DATA_WIDTH-1:0] env_word;
    logic [SUB_WIDTH-1:0]                    half_pipe [0:LAT-1];

    assign cmd_we = mem_write_en && (mem_write_sel == dsp_cmd_pkg::SEL_CMD);
    assign env_we = mem_write_en && (mem_write_sel == dsp_cmd_pkg::SEL_ENV);

    aligned_ram #(.DIN_WIDTH(dsp_cmd_pkg::CMD_WORD_WIDTH), .N_DIN_TO_DOUT(1),
                  .DOUT_ADDR_WIDTH(dsp_cfg_pkg::CMD_ADDR_WIDTH), .READ_LATENCY(LAT))
        cmd_mem (.clk(clk), .write_data(mem_write_data),
                 .write_addr(mem_write_addr[dsp_cfg_pkg::CMD_ADDR_WIDTH-1:0]),
                 .write_enable(cmd_we), .read_addr(cmd_read_addr), .read_data(cmd_data));

    aligned_ram #(.DIN_WIDTH(dsp_cfg_pkg::HOST_DATA_WIDTH), .N_DIN_TO_DOUT(1),
                  .DOUT_ADDR_WIDTH(ENV_WA_WIDTH), .READ_LATENCY(LAT))
        env_mem (.clk(clk), .write_data(mem_write_data),
                 .write_addr(mem_write_addr[ENV_WA_WIDTH-1:0]),
                 .write_enable(env_we),
                 .read_addr(env_read_addr[dsp_cfg_pkg::ENV_ADDR_WIDTH-1:SUB_WIDTH]),
                 .read_data(env_word));

    // half select travels alongside the memory read.
    always_ff @(posedge clk) begin
        half_pipe[0] <= env_read_addr[SUB_WIDTH-1:0];
        for (int s = 1; s < LAT; s++) begin
            half_pipe[s] <= half_pipe[s-1];
        end
    end

    assign env_data = env_word[half_pipe[LAT-1]*dsp_cfg_pkg::ENV_WIDTH +: dsp_cfg_pkg::ENV_WIDTH];

endmodule

/* verilog/aligned_ram.sv */
module aligned_ram #(
    parameter int DIN_WIDTH       = 32,
    parameter int N_DIN_TO_DOUT   = 1,
    parameter int DOUT_ADDR_WIDTH = 8,
    parameter int READ_LATENCY    = 1,
    localparam int WADDR_WIDTH    = DOUT_ADDR_WIDTH + $clog2(N_DIN_TO_DOUT),
    localparam int DOUT_WIDTH     = DIN_WIDTH * N_DIN_TO_DOUT
) (
    input  logic                       clk,
    input  logic [DIN_WIDTH-1:0]       write_data,
    input  logic [WADDR_WIDTH-1:0]     write_addr,
    input  logic                       write_enable,
    input  logic [DOUT_ADDR_WIDTH-1:0] read_addr,
    output logic [DOUT_WIDTH-1:0]      read_data
);

    logic [DIN_WIDTH-1:0]  mem [0:(1 << WADDR_WIDTH)-1];
    logic [DOUT_WIDTH-1:0] rd_word;
    logic [DOUT_WIDTH-1:0] rd_pipe [0:READ_LATENCY-1];

    always_ff @(posedge clk) begin
        if (write_enable) begin
            mem[write_addr] <= write_data;
        end
    end

    // lowest write address lands in the low bits.
    always_comb begin
        for (int k = 0; k < N_DIN_TO_DOUT; k++) begin
            rd_word[k*DIN_WIDTH +: DIN_WIDTH] = mem[read_addr * N_DIN_TO_DOUT + k];
        end
    end

    always_ff @(posedge clk) begin
        rd_pipe[0] <= rd_word;
        for (int s = 1; s < READ_LATENCY; s++) begin
            rd_pipe[s] <= rd_pipe[s-1];
        end
    end

    assign read_data = rd_pipe[READ_LATENCY-1];

    // once the enable is driven it must stay known.
    assert property (@(posedge clk)
        !$isunknown($past(write_enable)) |-> !$isunknown(write_enable));

endmodule

/* verilog/dsp_cmd_pkg.sv */
package dsp_cmd_pkg;

    localparam int CMD_WORD_WIDTH = 32;

    // ----------------------------------------
    // command word fields
    // ----------------------------------------
    localparam int OP_LSB    = 30;
    localparam int OP_WIDTH  = 2;
    localparam int ENV_LSB   = 20;  // envelope start, in samples.
    localparam int LEN_LSB   = 12;
    localparam int LEN_WIDTH = 8;
    localparam int AMP_LSB   = 0;
    localparam int AMP_WIDTH = 12;  // signed.

    localparam logic [OP_WIDTH-1:0] OP_END   = 2'd0;
    localparam logic [OP_WIDTH-1:0] OP_PULSE = 2'd1;
    localparam logic [OP_WIDTH-1:0] OP_ACQ   = 2'd2;

    // host memory select
    localparam int SEL_WIDTH = 3;
    localparam logic [SEL_WIDTH-1:0] SEL_CMD = 3'd0;
    localparam logic [SEL_WIDTH-1:0] SEL_ENV = 3'd1;

endpackage

/* verilog/dsp_cfg_pkg.sv */
package dsp_cfg_pkg;

    // ----------------------------------------
    // sample and host widths
    // ----------------------------------------
    localparam int ADC_WIDTH       = 16;
    localparam int DAC_WIDTH       = 16;
    localparam int ENV_WIDTH       = 16;  // two per host word.
    localparam int HOST_DATA_WIDTH = 32;
    localparam int HOST_ADDR_WIDTH = 16;

    // ----------------------------------------
    // memory sizes
    // ----------------------------------------
    localparam int CMD_ADDR_WIDTH  = 6;   // 64 commands.
    localparam int ENV_ADDR_WIDTH  = 10;  // in samples.
    localparam int ACQ_ADDR_WIDTH  = 8;
    localparam int ACC_ADDR_WIDTH  = 8;   // one entry per shot.
    localparam int ACC_WIDTH       = 32;

    // read latencies
    localparam int PARAM_READ_LATENCY = 2;
    localparam int BUF_READ_LATENCY   = 1;

endpackage
